//--- hdl/mem_pkg.sv
//--------------------------------------------------------------------------
// memory package
// geometry of the 128-bit word memory and the data types
// shared by the lane memories, the bridge and the top level
//--------------------------------------------------------------------------
package mem_pkg;

  // lane split
  localparam int LANE_BITS = 16;  // bits per lane memory
  localparam int NUM_LANES = 8;   // lanes side by side in one word

  // one lane's data
  typedef logic [LANE_BITS-1:0] lane_t;

  // full memory word, lane 0 in the low bits
  typedef logic [NUM_LANES*LANE_BITS-1:0] word_t;

  // one enable bit per lane
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // address in, data out after two edges
  localparam int READ_LATENCY = 2;

  localparam int DEFAULT_ADDR_BITS = 9;  // 512 words

endpackage

//--- hdl/wb_pkg.sv
//--------------------------------------------------------------------------
// wishbone package
// constants and state type of the port-B wishbone bridge
//--------------------------------------------------------------------------
package wb_pkg;

  // bridge FSM, one transaction at a time
  typedef enum logic [1:0] {
    WB_IDLE = 2'd0,  // waiting for cyc and stb
    WB_BUSY = 2'd1,  // access issued, read data in flight
    WB_ACK  = 2'd2   // single ack cycle
  } wb_state_t;

  // busy cycles between issue and ack
  localparam int WAIT_CYCLES = mem_pkg::READ_LATENCY;

  typedef logic [1:0] wait_cnt_t;  // wide enough for WAIT_CYCLES-1

endpackage

//--- hdl/mem_port_if.sv
//--------------------------------------------------------------------------
// memory port interface
// port-B memory side, from the wishbone bridge to the eight lanes
//--------------------------------------------------------------------------
`timescale 1ns/1ns

interface mem_port_if #(
  parameter int addr_bits = mem_pkg::DEFAULT_ADDR_BITS
) ();

  logic [addr_bits-1:0] addr;   // word address, shared by all lanes
  mem_pkg::lane_mask_t  wmask;  // per-lane write strobe, issue cycle only
  mem_pkg::word_t       wdata;  // write word

  // each lane drives its own slice, hence a net
  wire mem_pkg::word_t  rdata;

  // bridge side
  modport initiator (
    output addr,
    output wmask,
    output wdata,
    input  rdata
  );

  // lane side
  modport target (
    input  addr,
    input  wmask,
    input  wdata,
    output rdata
  );

endinterface

//--- hdl/lane_ram.sv
//--------------------------------------------------------------------------
// lane memory
// one 16-bit slice of the word memory, two write ports, read before
// write, two-stage registered reads on both ports
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module lane_ram #(
  parameter int addr_bits = mem_pkg::DEFAULT_ADDR_BITS,
  parameter int lane      = 0   // which slice of the port-B word
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [addr_bits-1:0] a_addr,
  input  logic                 a_we,
  input  mem_pkg::lane_t       a_din,
  output mem_pkg::lane_t       a_dout,
  mem_port_if.target           b_port
);

  localparam int depth = 2 ** addr_bits;
  localparam int lo    = lane * mem_pkg::LANE_BITS;  // slice base in the word

  mem_pkg::lane_t mem [depth];  // storage, no reset

  mem_pkg::lane_t a_rd;  // first read stage, port A
  mem_pkg::lane_t b_rd;  // first read stage, port B
  mem_pkg::lane_t b_q;   // second read stage, port B

  logic           b_we;
  mem_pkg::lane_t b_din;

  assign b_we  = b_port.wmask[lane];                            // own mask bit
  assign b_din = b_port.wdata[lo +: mem_pkg::LANE_BITS];        // own slice

  //------------------------------------------------------------------------
  // write ports
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_din;
    end
    // port B comes second so it wins a same-address collision
    if (b_we) begin
      mem[b_port.addr] <= b_din;
    end
  end

  //------------------------------------------------------------------------
  // read pipeline
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      a_rd   <= '0;
      b_rd   <= '0;
      a_dout <= '0;  // zero until the first read drains through
      b_q    <= '0;
    end else begin
      a_rd   <= mem[a_addr];      // old contents, same edge as a write
      b_rd   <= mem[b_port.addr];
      a_dout <= a_rd;             // output register
      b_q    <= b_rd;
    end
  end

  assign b_port.rdata[lo +: mem_pkg::LANE_BITS] = b_q;

endmodule

//--- hdl/wb_port.sv
//--------------------------------------------------------------------------
// wishbone port
// classic slave on port B, one issue cycle per bus cycle and a
// fixed three-cycle request to ack time for reads and writes
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module wb_port #(
  parameter int addr_bits = mem_pkg::DEFAULT_ADDR_BITS
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [addr_bits-1:0] wb_adr,
  input  mem_pkg::word_t       wb_dat_w,
  input  mem_pkg::lane_mask_t  wb_sel,
  output mem_pkg::word_t       wb_dat_r,
  output logic                 wb_ack,
  mem_port_if.initiator        mem
);

  wb_pkg::wb_state_t state;
  wb_pkg::wait_cnt_t cnt;      // busy cycles left after this one

  logic req;                   // host request, cyc and stb
  logic issue;                 // access handed to the lanes this cycle
  logic last_wait;             // read data reaches rdata this cycle

  assign req       = wb_cyc && wb_stb;
  assign issue     = (state == wb_pkg::WB_IDLE) && req;
  assign last_wait = (state == wb_pkg::WB_BUSY) && (cnt == '0);

  //------------------------------------------------------------------------
  // memory side
  //------------------------------------------------------------------------
  // host holds adr and dat until ack, so no capture needed here
  assign mem.addr  = wb_adr;
  assign mem.wdata = wb_dat_w;
  assign mem.wmask = (issue && wb_we) ? wb_sel : '0;  // reads never write

  //------------------------------------------------------------------------
  // bridge FSM
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wb_pkg::WB_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        wb_pkg::WB_IDLE: begin
          if (issue) begin
            state <= wb_pkg::WB_BUSY;
            cnt   <= wb_pkg::wait_cnt_t'(wb_pkg::WAIT_CYCLES - 1);
          end
        end
        wb_pkg::WB_BUSY: begin
          if (!req) begin
            state <= wb_pkg::WB_IDLE;  // host gave up, drop the access
          end else if (cnt == '0) begin
            state <= wb_pkg::WB_ACK;
          end else begin
            cnt <= cnt - 1'b1;         // count down read latency
          end
        end
        wb_pkg::WB_ACK: begin
          state <= wb_pkg::WB_IDLE;    // ack lasts one cycle
        end
        default: begin
          state <= wb_pkg::WB_IDLE;
        end
      endcase
    end
  end

  // read data, old contents on a write cycle too
  always_ff @(posedge clk) begin
    if (last_wait) begin
      wb_dat_r <= mem.rdata;
    end
  end

  assign wb_ack = (state == wb_pkg::WB_ACK);  // low from reset, state is idle

endmodule

//--- hdl/bram_128.sv
//--------------------------------------------------------------------------
// 128-bit dual-port block memory
// eight 16-bit lanes on one address, port A for the data cache,
// port B as a wishbone classic slave with per-lane selects
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module bram_128 #(
  parameter int addr_bits = mem_pkg::DEFAULT_ADDR_BITS  // depth is 2**addr_bits
) (
  input  logic                 clk,
  input  logic                 rst,

  // port A, cache side
  input  logic [addr_bits-1:0] addr,
  input  logic                 we,
  input  mem_pkg::word_t       din,
  output mem_pkg::word_t       dout,   // two cycles after addr

  // port B, wishbone classic slave
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [addr_bits-1:0] wb_adr,
  input  mem_pkg::word_t       wb_dat_w,
  input  mem_pkg::lane_mask_t  wb_sel,
  output mem_pkg::word_t       wb_dat_r,
  output logic                 wb_ack
);

  // port-B memory side, bridge to lanes
  mem_port_if #(.addr_bits(addr_bits)) b_if ();

  //------------------------------------------------------------------------
  // wishbone bridge
  //------------------------------------------------------------------------
  wb_port #(
    .addr_bits (addr_bits)
  ) wb_port_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .mem      (b_if.initiator)
  );

  //------------------------------------------------------------------------
  // lane memories
  //------------------------------------------------------------------------
  for (genvar i = 0; i < mem_pkg::NUM_LANES; i++) begin : lane_gen
    lane_ram #(
      .addr_bits (addr_bits),
      .lane      (i)
    ) lane_ram_i (
      .clk    (clk),
      .rst    (rst),
      .a_addr (addr),                                           // shared address
      .a_we   (we),                                             // whole word on port A
      .a_din  (din[i*mem_pkg::LANE_BITS +: mem_pkg::LANE_BITS]),
      .a_dout (dout[i*mem_pkg::LANE_BITS +: mem_pkg::LANE_BITS]),
      .b_port (b_if.target)
    );
  end

endmodule

//--- dv/bram_128_props.sv
//--------------------------------------------------------------------------
// bram_128 properties
// reset and wishbone handshake assertions, bound into the top level
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module bram_128_props (
  input logic                clk,
  input logic                rst,
  input logic                wb_cyc,
  input logic                wb_stb,
  input logic                wb_ack,
  input mem_pkg::lane_mask_t wmask,
  input mem_pkg::word_t      dout
);

  int fails = 0;  // failed assertions so far

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else begin
      fails++;
      $error("wb_ack stayed high for a second cycle");
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
                                 wb_ack |-> (wb_cyc && wb_stb))
    else begin
      fails++;
      $error("wb_ack high without cyc and stb");
    end

  // mask only in the issue cycle, then two quiet busy cycles and the ack
  mask_issue_only: assert property (@(posedge clk) disable iff (rst)
                                    (wmask != '0) |=>
                                    (wmask == '0) [*2] ##1 (wb_ack && (wmask == '0)))
    else begin
      fails++;
      $error("port-B write mask set outside the issue cycle");
    end

  dout_cleared: assert property (@(posedge clk) rst |=> (dout == '0))
    else begin
      fails++;
      $error("dout not zero in the cycle after reset");
    end

endmodule

bind bram_128 bram_128_props props_i (
  .clk    (clk),
  .rst    (rst),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .wmask  (b_if.wmask),
  .dout   (dout)
);

//--- dv/bram_128_checker.sv
//--------------------------------------------------------------------------
// bram_128 checker
// reference model of the word memory, port-A read pipeline and
// wishbone ack prediction, compared with the DUT on every edge
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module bram_128_checker #(
  parameter int addr_bits = mem_pkg::DEFAULT_ADDR_BITS
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [addr_bits-1:0] addr,
  input  logic                 we,
  input  mem_pkg::word_t       din,
  input  mem_pkg::word_t       dout,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [addr_bits-1:0] wb_adr,
  input  mem_pkg::word_t       wb_dat_w,
  input  mem_pkg::lane_mask_t  wb_sel,
  input  mem_pkg::word_t       wb_dat_r,
  input  logic                 wb_ack,
  input  int                   test_id,
  output int                   errors
);

  localparam int lat       = mem_pkg::READ_LATENCY;
  localparam int ack_delay = 3;                 // request edge to ack edge
  localparam int lb        = mem_pkg::LANE_BITS;

  mem_pkg::word_t model [2 ** addr_bits];       // X until written
  mem_pkg::word_t pipe  [lat];                  // expected dout, oldest last
  mem_pkg::word_t b_exp;                        // expected wb_dat_r
  int             ack_cd;                       // edges to ack, 0 when idle
  logic           seen_rst;

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset_values";
      1:       return "fill_readback";
      2:       return "random_port_a";
      3:       return "wb_read";
      4:       return "wb_masked_write";
      default: return "unknown";
    endcase
  endfunction

  task automatic mismatch(input string what, input mem_pkg::word_t expected,
                          input mem_pkg::word_t actual);
    errors++;
    $display("MISMATCH %s %s expected %h actual %h", test_name(test_id), what,
             expected, actual);
  endtask

  task automatic fault(input string what);
    errors++;
    $display("%s: %s", test_name(test_id), what);
  endtask

  initial begin
    errors   = 0;
    ack_cd   = 0;
    seen_rst = 1'b0;
  end

  always @(posedge clk) begin : watch
    logic issue;
    issue = seen_rst && !rst && wb_cyc && wb_stb && (ack_cd == 0);

    // port A, words never written are skipped
    if (!$isunknown(pipe[lat-1]) && dout !== pipe[lat-1]) begin
      mismatch("dout", pipe[lat-1], dout);
    end

    // port B, ack only in its slot
    if (seen_rst) begin
      if (ack_cd == 1) begin
        if (wb_ack !== 1'b1) begin
          fault("wb_ack missing three cycles after the request");
        end else if (!$isunknown(b_exp) && wb_dat_r !== b_exp) begin
          mismatch("wb_dat_r", b_exp, wb_dat_r);
        end
      end else if (wb_ack !== 1'b0) begin
        fault("wb_ack high outside its one-cycle slot");
      end
    end
    if (ack_cd > 0) begin
      ack_cd--;
    end

    // reads see the contents from before this edge's writes
    if (rst) begin
      foreach (pipe[i]) begin
        pipe[i] = '0;       // both output stages cleared
      end
      ack_cd = 0;
    end else begin
      for (int i = lat - 1; i > 0; i--) begin
        pipe[i] = pipe[i-1];
      end
      pipe[0] = model[addr];
    end
    if (issue) begin
      b_exp  = model[wb_adr];  // old word, writes too
      ack_cd = ack_delay;
    end

    // port A first, port B's selected lanes land on top
    if (we) begin
      model[addr] = din;
    end
    if (issue && wb_we) begin
      for (int i = 0; i < mem_pkg::NUM_LANES; i++) begin
        if (wb_sel[i]) begin
          model[wb_adr][i*lb +: lb] = wb_dat_w[i*lb +: lb];
        end
      end
    end
    if (rst) begin
      seen_rst = 1'b1;
    end
  end

endmodule

//--- dv/bram_128_tb.sv
//--------------------------------------------------------------------------
// bram_128 testbench
// clock, reset, random port-A and wishbone stimulus, watchdog
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module bram_128_tb;

  localparam int addr_bits    = 6;    // 64 words, not the default depth
  localparam int depth        = 2 ** addr_bits;
  localparam int reset_cycles = 16;
  localparam int n_random     = 400;
  localparam int n_wb         = 40;   // wishbone reads, and as many writes
  localparam int n_collide    = 16;
  // no operation takes more than five cycles
  localparam int total_ops    = 3 * depth + n_random + 2 * n_wb + 2 * n_collide;
  localparam int limit_cycles = total_ops * 5 + reset_cycles;

  typedef logic [addr_bits-1:0] addr_t;

  logic                clk;
  logic                rst;
  addr_t               addr;
  logic                we;
  mem_pkg::word_t      din;
  mem_pkg::word_t      dout;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  addr_t               wb_adr;
  mem_pkg::word_t      wb_dat_w;
  mem_pkg::lane_mask_t wb_sel;
  mem_pkg::word_t      wb_dat_r;
  logic                wb_ack;

  integer seed;
  int     test_id;      // names the test in checker reports
  int     errors;       // counted by the checker
  int     tb_errors;    // handshake failures
  int     last_errors;

  bram_128 #(.addr_bits(addr_bits)) bram_128_i (.*);

  bram_128_checker #(.addr_bits(addr_bits)) check_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin : watchdog
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run still going after %0d cycles", limit_cycles);
    $display("Test failed");
    $finish;
  end

  //------------------------------------------------------------------------
  // stimulus helpers
  //------------------------------------------------------------------------
  function automatic mem_pkg::word_t rand_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // wishbone reads go to the upper half, port-A traffic to the lower
  function automatic addr_t rand_addr(input logic pick_half, input logic upper);
    addr_t a;
    a = addr_t'($random(seed));
    if (pick_half) begin
      a[addr_bits-1] = upper;
    end
    return a;
  endfunction

  function automatic int fail_count();
    return errors + tb_errors + bram_128_i.props_i.fails;
  endfunction

  task automatic drive_porta(input addr_t a, input logic w, input mem_pkg::word_t d);
    @(posedge clk);
    addr <= a;
    we   <= w;
    din  <= d;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      we <= 1'b0;
    end
  endtask

  // one bus cycle; also_a adds a port-A write on the same edge and address,
  // load keeps port A writing the lower half until ack
  task automatic wb_access(input logic w, input addr_t a, input logic also_a,
                           input logic load);
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= w;
    wb_adr   <= a;
    wb_dat_w <= rand_word();
    wb_sel   <= w ? mem_pkg::lane_mask_t'($random(seed)) : '0;  // no strobes on reads
    if (also_a) begin
      addr <= a;
      we   <= 1'b1;
      din  <= rand_word();
    end
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      we <= load;     // collision write lasts one edge only
      if (load) begin
        addr <= rand_addr(1'b1, 1'b0);
        din  <= rand_word();
      end
    end while (!wb_ack && waited < 10);
    if (!wb_ack) begin
      tb_errors++;
      $display("wb_ack did not arrive within %0d cycles of the request", waited);
    end
    wb_cyc <= 1'b0;   // host drops the cycle after ack
    wb_stb <= 1'b0;
    we     <= 1'b0;
  endtask

  task automatic end_test(input string name);
    int total;
    idle(3);          // drain the read pipeline
    @(negedge clk);   // counts settled away from the edge
    total = fail_count();
    $display("test %-16s done, %0d errors", name, total - last_errors);
    last_errors = total;
    test_id++;
  endtask

  //------------------------------------------------------------------------
  // test sequence
  //------------------------------------------------------------------------
  initial begin : main
    seed        = 6;
    rst         = 1'b1;
    addr        = '0;
    we          = 1'b0;
    din         = '0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    wb_sel      = '0;
    test_id     = 0;
    tb_errors   = 0;
    last_errors = 0;

    repeat (reset_cycles) @(posedge clk);  // checker wants zero dout, no ack
    rst <= 1'b0;
    end_test("reset_values");

    for (int i = 0; i < depth; i++) begin
      drive_porta(addr_t'(i), 1'b1, rand_word());
    end
    for (int i = 0; i < depth; i++) begin
      drive_porta(addr_t'(i), 1'b0, '0);
    end
    end_test("fill_readback");

    repeat (n_random) begin
      drive_porta(rand_addr(1'b0, 1'b0), 1'($random(seed)), rand_word());
    end
    end_test("random_port_a");

    repeat (n_wb) begin
      wb_access(1'b0, rand_addr(1'b1, 1'b1), 1'b0, 1'b1);
    end
    end_test("wb_read");

    repeat (n_wb) begin
      wb_access(1'b1, rand_addr(1'b0, 1'b0), 1'b0, 1'b0);
    end
    for (int i = 0; i < depth; i++) begin
      drive_porta(addr_t'(i), 1'b0, '0);   // lanes as the masks left them
    end
    repeat (n_collide) begin
      wb_access(1'b1, rand_addr(1'b0, 1'b0), 1'b1, 1'b0);
      drive_porta(wb_adr, 1'b0, '0);       // merged word, wb_adr still held
    end
    end_test("wb_masked_write");

    $display("%0d tests run, %0d errors", test_id, fail_count());
    if (fail_count() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/mem_pkg.sv
hdl/wb_pkg.sv
hdl/mem_port_if.sv
hdl/lane_ram.sv
hdl/wb_port.sv
hdl/bram_128.sv
dv/bram_128_props.sv
dv/bram_128_checker.sv
dv/bram_128_tb.sv
